// ==== include/cache_defs.svh ====
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// Processor side widths
`define CACHE_WORD_W         32
`define CACHE_PROC_ADDR_W    30

// Memory side widths, word 0 in the low bits of a block
`define CACHE_WORDS_PER_LINE 4
`define CACHE_BLOCK_W        (`CACHE_WORD_W * `CACHE_WORDS_PER_LINE)
`define CACHE_MEM_ADDR_W     28

`endif

// ==== hw/cache_pkg.sv ====
`default_nettype none

`include "cache_defs.svh"

package cache_pkg;

    // Words in one cache line
    localparam int words_per_line = `CACHE_WORDS_PER_LINE;

    // Data types
    typedef logic [`CACHE_WORD_W-1:0]  word_t;
    typedef logic [`CACHE_BLOCK_W-1:0] block_t;

    // Processor word address and memory block address
    typedef logic [`CACHE_PROC_ADDR_W-1:0] proc_addr_t;
    typedef logic [`CACHE_MEM_ADDR_W-1:0]  mem_addr_t;

    // Miss handling states
    typedef enum logic [1:0] {
        st_idle       = 2'b00,
        st_write_back = 2'b01,
        st_refill     = 2'b10,
        st_unused     = 2'b11
    } cache_state_e;

endpackage

`default_nettype wire

// ==== hw/cache_array_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface cache_array_if;
    import cache_pkg::*;

    ////////////////////////////////////////////////////////////
    // Lookup results from the line store
    ////////////////////////////////////////////////////////////
    logic      hit;
    logic      dirty;
    mem_addr_t victim_addr;

    ////////////////////////////////////////////////////////////
    // Update strobes from the controller
    ////////////////////////////////////////////////////////////
    logic      word_we;
    logic      fill_en;

    modport ctrl (
        input  hit,
        input  dirty,
        input  victim_addr,
        output word_we,
        output fill_en
    );

    modport store (
        output hit,
        output dirty,
        output victim_addr,
        input  word_we,
        input  fill_en
    );

endinterface

`default_nettype wire

// ==== hw/cache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  proc_read,
    input  logic                  proc_write,
    input  logic                  mem_ready,
    cache_array_if.ctrl           arr,
    input  cache_pkg::proc_addr_t proc_addr,
    output logic                  proc_stall,
    output logic                  mem_read,
    output logic                  mem_write,
    output cache_pkg::mem_addr_t  mem_addr
);
    import cache_pkg::*;

    cache_state_e state_q;
    cache_state_e state_d;
    logic         req;

    // Any processor access pending
    assign req = proc_read | proc_write;

    ////////////////////////////////////////////////////////////
    // State register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    ////////////////////////////////////////////////////////////
    // Next state
    ////////////////////////////////////////////////////////////
    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                // Dirty victim goes out before the new line comes in
                if (req && !arr.hit) begin
                    if (arr.dirty) begin
                        state_d = st_write_back;
                    end else begin
                        state_d = st_refill;
                    end
                end
            end
            st_write_back: begin
                if (mem_ready) begin
                    state_d = st_refill;
                end
            end
            st_refill: begin
                // Line is valid next cycle, the access then hits
                if (mem_ready) begin
                    state_d = st_idle;
                end
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Processor side
    ////////////////////////////////////////////////////////////

    // Held while a miss is being served
    assign proc_stall = req && ((state_q != st_idle) || !arr.hit);

    // Write hits go straight into the array
    assign arr.word_we = (state_q == st_idle) && proc_write && arr.hit;

    // Capture the refill block only when memory answers
    assign arr.fill_en = (state_q == st_refill) && mem_ready;

    ////////////////////////////////////////////////////////////
    // Memory side
    ////////////////////////////////////////////////////////////

    // Requests follow the next state
    assign mem_read  = (state_d == st_refill);
    assign mem_write = (state_d == st_write_back);

    // Victim block on write back, else block of the request
    always_comb begin
        if (state_d == st_write_back) begin
            mem_addr = arr.victim_addr;
        end else begin
            mem_addr = proc_addr[$bits(proc_addr_t)-1 -: $bits(mem_addr_t)];
        end
    end

    // Only one memory request at a time
    a_mem_req_onehot: assert property (
        @(posedge clk) disable iff (!rst_n) !(mem_read && mem_write)
    ) else $error("mem_read and mem_write asserted together");

    a_state_legal: assert property (
        @(posedge clk) disable iff (!rst_n) state_q != st_unused
    ) else $error("controller entered an unused state");

endmodule

`default_nettype wire

// ==== hw/cache_line_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_line_store #(
    parameter int line_count = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    cache_array_if.store          arr,
    input  cache_pkg::proc_addr_t proc_addr,
    input  cache_pkg::word_t      proc_wdata,
    input  cache_pkg::block_t     mem_rdata,
    output cache_pkg::word_t      proc_rdata,
    output cache_pkg::block_t     mem_wdata
);
    import cache_pkg::*;

    // Address split is offset, index, then tag in the top bits
    localparam int word_w   = $bits(word_t);
    localparam int offset_w = $clog2(words_per_line);
    localparam int index_w  = $clog2(line_count);
    localparam int tag_w    = $bits(mem_addr_t) - index_w;

    ////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////
    block_t                data_q [line_count];
    logic [tag_w-1:0]      tag_q  [line_count];
    logic [line_count-1:0] valid_q;
    logic [line_count-1:0] dirty_q;

    // Fields of the current processor address
    logic [offset_w-1:0]   offset;
    logic [index_w-1:0]    index;
    logic [tag_w-1:0]      tag;

    assign offset = proc_addr[offset_w-1:0];
    assign index  = proc_addr[offset_w +: index_w];
    assign tag    = proc_addr[offset_w + index_w +: tag_w];

    ////////////////////////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////////////////////////

    // Invalid lines never hit, whatever their tag holds
    assign arr.hit = valid_q[index] && (tag_q[index] == tag);

    assign arr.dirty = dirty_q[index];

    // Block address of whatever line sits at this index
    assign arr.victim_addr = {tag_q[index], index};

    // Selected word for reads
    assign proc_rdata = data_q[index][offset*word_w +: word_w];

    // Whole line for write back
    assign mem_wdata = data_q[index];

    ////////////////////////////////////////////////////////////
    // Data and tag update
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (arr.fill_en) begin
            data_q[index] <= mem_rdata;
            tag_q[index]  <= tag;
        end else if (arr.word_we) begin
            data_q[index][offset*word_w +: word_w] <= proc_wdata;
        end
    end

    ////////////////////////////////////////////////////////////
    // Valid and dirty bits
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (arr.fill_en) begin
            // Fresh line matches memory
            valid_q[index] <= 1'b1;
            dirty_q[index] <= 1'b0;
        end else if (arr.word_we) begin
            dirty_q[index] <= 1'b1;
        end
    end

    // Fill and word write come from different controller states
    a_update_onehot: assert property (
        @(posedge clk) disable iff (!rst_n) !(arr.word_we && arr.fill_en)
    ) else $error("word write and line fill in the same cycle");

endmodule

`default_nettype wire

// ==== hw/cache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_top #(
    parameter int line_count = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,

    // Processor port
    input  logic                  proc_read,
    input  logic                  proc_write,
    input  cache_pkg::proc_addr_t proc_addr,
    input  cache_pkg::word_t      proc_wdata,
    output logic                  proc_stall,
    output cache_pkg::word_t      proc_rdata,

    // Memory port
    output logic                  mem_read,
    output logic                  mem_write,
    output cache_pkg::mem_addr_t  mem_addr,
    input  cache_pkg::block_t     mem_rdata,
    output cache_pkg::block_t     mem_wdata,
    input  logic                  mem_ready
);

    // Lookup results and update strobes
    cache_array_if arr_if ();

    cache_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .proc_read  (proc_read),
        .proc_write (proc_write),
        .mem_ready  (mem_ready),
        .arr        (arr_if.ctrl),
        .proc_addr  (proc_addr),
        .proc_stall (proc_stall),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr)
    );

    cache_line_store #(
        .line_count (line_count)
    ) u_store (
        .clk        (clk),
        .rst_n      (rst_n),
        .arr        (arr_if.store),
        .proc_addr  (proc_addr),
        .proc_wdata (proc_wdata),
        .mem_rdata  (mem_rdata),
        .proc_rdata (proc_rdata),
        .mem_wdata  (mem_wdata)
    );

endmodule

`default_nettype wire

// ==== test/mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_model #(
    parameter int                   block_count = 64,
    parameter cache_pkg::mem_addr_t base_block  = '0
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 mem_read,
    input  logic                 mem_write,
    input  cache_pkg::mem_addr_t mem_addr,
    input  cache_pkg::block_t    mem_wdata,
    input  logic [2:0]           delay,
    output cache_pkg::block_t    mem_rdata,
    output logic                 mem_ready,
    // One pulse per block written back
    output logic                 log_valid,
    output cache_pkg::mem_addr_t log_addr,
    output cache_pkg::block_t    log_data
);
    import cache_pkg::*;

    localparam int slot_w = $clog2(block_count);

    block_t            blocks [block_count];
    logic              busy;
    logic [2:0]        count;
    logic [slot_w-1:0] slot;

    // Window is aligned, so the low bits pick the block
    assign slot = mem_addr[slot_w-1:0];

    // Initial contents, every word a function of its full word address
    function automatic block_t fill_block(input mem_addr_t blk);
        block_t     data;
        proc_addr_t a;
        data = '0;
        for (int w = 0; w < words_per_line; w++) begin
            a = {blk, 2'(w)};
            data[w*$bits(word_t) +: $bits(word_t)] = {2'b01, a} ^ (word_t'(a) << 13);
        end
        return data;
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int b = 0; b < block_count; b++) begin
                blocks[b] <= fill_block(base_block | mem_addr_t'(b));
            end
            busy      <= 1'b0;
            count     <= 3'd0;
            mem_ready <= 1'b0;
            mem_rdata <= '0;
            log_valid <= 1'b0;
            log_addr  <= '0;
            log_data  <= '0;
        end else begin
            log_valid <= 1'b0;
            if (mem_ready) begin
                // Handshake taken at this edge
                mem_ready <= 1'b0;
                busy      <= 1'b0;
            end else if (busy && count != 3'd0) begin
                count <= count - 3'd1;
            end else if (busy) begin
                if (mem_write) begin
                    blocks[slot] <= mem_wdata;
                    log_valid    <= 1'b1;
                    log_addr     <= mem_addr;
                    log_data     <= mem_wdata;
                end else begin
                    mem_rdata <= blocks[slot];
                end
                mem_ready <= 1'b1;
            end else if (mem_read || mem_write) begin
                busy  <= 1'b1;
                count <= delay;
            end
        end
    end

endmodule

`default_nettype wire

// ==== test/cache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_defs.svh"

module cache_tb;
    import cache_pkg::*;

    localparam int        line_count    = 8;
    localparam int        window_blocks = 64;
    localparam int        window_words  = window_blocks * words_per_line;
    localparam int        random_ops    = 400;
    localparam int        planned_ops   = 8 + random_ops + window_words;
    localparam int        clk_period    = 20;
    localparam int        timeout_ns    = (10 + planned_ops * 200) * clk_period;
    localparam mem_addr_t base_block    = 28'h0ABC_D00;

    // Two blocks that share index 5
    localparam mem_addr_t blk_a = base_block | 28'h05;
    localparam mem_addr_t blk_b = base_block | 28'h0D;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       proc_read;
    logic       proc_write;
    proc_addr_t proc_addr;
    word_t      proc_wdata;
    logic       proc_stall;
    word_t      proc_rdata;
    logic       mem_read;
    logic       mem_write;
    mem_addr_t  mem_addr;
    block_t     mem_rdata;
    block_t     mem_wdata;
    logic       mem_ready;
    logic [2:0] mem_delay;
    logic       log_valid;
    mem_addr_t  log_addr;
    block_t     log_data;

    int    seed = 32'h5306_1bf7;
    word_t golden [window_words];

    always #(clk_period / 2) clk = ~clk;

    cache_top #(
        .line_count (line_count)
    ) dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .proc_read  (proc_read),
        .proc_write (proc_write),
        .proc_addr  (proc_addr),
        .proc_wdata (proc_wdata),
        .proc_stall (proc_stall),
        .proc_rdata (proc_rdata),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_rdata  (mem_rdata),
        .mem_wdata  (mem_wdata),
        .mem_ready  (mem_ready)
    );

    mem_model #(
        .block_count (window_blocks),
        .base_block  (base_block)
    ) mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .delay     (mem_delay),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready),
        .log_valid (log_valid),
        .log_addr  (log_addr),
        .log_data  (log_data)
    );

    ////////////////////////////////////////////////////////////
    // Golden model
    ////////////////////////////////////////////////////////////
    function automatic word_t fill_word(input proc_addr_t a);
        return {2'b01, a} ^ (word_t'(a) << 13);
    endfunction

    function automatic word_t expected_word(input proc_addr_t a);
        return golden[a[7:0]];
    endfunction

    function automatic block_t expected_block(input mem_addr_t b);
        block_t blk;
        blk = '0;
        for (int w = 0; w < words_per_line; w++) begin
            blk[w*`CACHE_WORD_W +: `CACHE_WORD_W] = golden[{b[5:0], 2'(w)}];
        end
        return blk;
    endfunction

    function automatic proc_addr_t word_addr(input mem_addr_t b, input int w);
        return {b, 2'(w)};
    endfunction

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////
    task automatic report_failure();
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
            report_failure();
        end
    endtask

    task automatic check_block(input block_t got, input block_t exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
            report_failure();
        end
    endtask

    task automatic check_mem_addr(input mem_addr_t got, input mem_addr_t exp,
                                  input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
            report_failure();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
            report_failure();
        end
    endtask

    // Reads are checked the half cycle before they complete
    initial begin : compare_proc
        for (int i = 0; i < window_words; i++) begin
            golden[i] = fill_word({base_block[27:6], 8'(i)});
        end
        forever begin
            @(negedge clk);
            if (rst_n) begin
                if (proc_read && !proc_stall) begin
                    check_word(proc_rdata, expected_word(proc_addr), "read data");
                end
                if (proc_write && !proc_stall) begin
                    golden[proc_addr[7:0]] = proc_wdata;
                end
                if (log_valid) begin
                    check_block(log_data, expected_block(log_addr), "write-back block");
                end
                if ((mem_read || mem_write) && mem_addr[27:6] != base_block[27:6]) begin
                    $display("Memory request to block %h falls outside the test window",
                             mem_addr);
                    report_failure();
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Processor side requests
    ////////////////////////////////////////////////////////////
    task automatic start_request(input logic is_write, input proc_addr_t addr,
                                 input word_t data);
        int rnd;
        rnd        = $random(seed);
        mem_delay  = 3'($unsigned(rnd) % 32'd6);
        proc_addr  = addr;
        proc_wdata = data;
        proc_read  = !is_write;
        proc_write = is_write;
    endtask

    // Called at a falling edge, drops the request after it completes
    task automatic finish_request();
        while (proc_stall) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        proc_read  = 1'b0;
        proc_write = 1'b0;
    endtask

    task automatic cache_access(input logic is_write, input proc_addr_t addr,
                                input word_t data);
        start_request(is_write, addr, data);
        @(negedge clk);
        finish_request();
    endtask

    initial begin : stimulus
        int rnd;
        rst_n      = 1'b0;
        proc_read  = 1'b0;
        proc_write = 1'b0;
        proc_addr  = '0;
        proc_wdata = '0;
        mem_delay  = 3'd0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Idle after reset
        @(negedge clk);
        check_flag(proc_stall, 1'b0, "proc_stall after reset");
        check_flag(mem_read, 1'b0, "mem_read after reset");
        check_flag(mem_write, 1'b0, "mem_write after reset");
        @(posedge clk);
        #1;

        // Cold read goes straight to refill
        start_request(1'b0, word_addr(blk_a, 1), '0);
        @(negedge clk);
        check_flag(proc_stall, 1'b1, "proc_stall on cold read");
        check_flag(mem_read, 1'b1, "mem_read on cold read");
        check_flag(mem_write, 1'b0, "mem_write on cold read");
        check_mem_addr(mem_addr, blk_a, "refill address");
        finish_request();

        // Hit on another word of the same line
        start_request(1'b0, word_addr(blk_a, 2), '0);
        @(negedge clk);
        check_flag(proc_stall, 1'b0, "proc_stall on read hit");
        check_flag(mem_read, 1'b0, "mem_read on read hit");
        check_flag(mem_write, 1'b0, "mem_write on read hit");
        finish_request();

        // Write hit, then read it back
        start_request(1'b1, word_addr(blk_a, 3), 32'hCAFE_0001);
        @(negedge clk);
        check_flag(proc_stall, 1'b0, "proc_stall on write hit");
        check_flag(mem_read, 1'b0, "mem_read on write hit");
        check_flag(mem_write, 1'b0, "mem_write on write hit");
        finish_request();
        start_request(1'b0, word_addr(blk_a, 3), '0);
        @(negedge clk);
        check_flag(proc_stall, 1'b0, "proc_stall on read after write");
        check_word(proc_rdata, 32'hCAFE_0001, "read after write hit");
        finish_request();

        // Conflict on the dirty line
        start_request(1'b0, word_addr(blk_b, 0), '0);
        @(negedge clk);
        check_flag(mem_write, 1'b1, "mem_write on dirty miss");
        check_flag(mem_read, 1'b0, "mem_read on dirty miss");
        check_mem_addr(mem_addr, blk_a, "write-back address");
        while (!log_valid) begin
            @(negedge clk);
        end
        check_mem_addr(log_addr, blk_a, "logged write-back address");
        check_block(log_data, expected_block(blk_a), "evicted block");
        check_flag(mem_read, 1'b1, "mem_read after write-back");
        check_mem_addr(mem_addr, blk_b, "refill address after write-back");
        finish_request();

        ////////////////////////////////////////////////////////////
        // Random mix over the conflict window
        ////////////////////////////////////////////////////////////
        for (int i = 0; i < random_ops; i++) begin
            rnd = $random(seed);
            cache_access(rnd[8], {base_block[27:6], rnd[7:0]}, $random(seed));
        end

        // Whole window read back against the golden array
        for (int i = 0; i < window_words; i++) begin
            cache_access(1'b0, {base_block[27:6], 8'(i)}, '0);
        end

        $display("Simulation completed successfully");
        $finish;
    end

    initial begin : watchdog
        #(timeout_ns);
        $display("Timeout at %0t: the run hung waiting for the cache", $time);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+include
hw/cache_pkg.sv
hw/cache_array_if.sv
hw/cache_ctrl.sv
hw/cache_line_store.sv
hw/cache_top.sv
test/mem_model.sv
test/cache_tb.sv

// ==== Makefile ====
# Verilator build and run for the cache testbench

VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard include/*.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source, a header or the file list changes
$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Exit status of the simulator is the pass or fail result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
